/* common/mini_mcu_params.svh */
/*
 * Sizes and address map of the mini MCU slice.
 * Include where bank counts, depths or windows are needed.
 */
`ifndef MINI_MCU_PARAMS_SVH
`define MINI_MCU_PARAMS_SVH

// memory banks, contiguous from MEM_BASE
`define MEM_BANKS 4
`define BANK_WORDS 256
`define MEM_BASE 32'h0000_0000

// control peripheral window
`define PERIPH_BASE 32'h0002_0000
`define PERIPH_SIZE 32'd16

// read-only id at peripheral offset 8
`define SOC_ID 32'h4d43_5531

`endif

/* common/mini_mcu_pkg.sv */
/*
 * Shared bus types for the mini MCU slice.
 * Referenced by scoped name from the bus, memory and peripheral blocks.
 */
`default_nettype none

package mini_mcu_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // byte address
  typedef logic [ADDR_W-1:0] obi_addr_t;

  // bus data word
  typedef logic [DATA_W-1:0] obi_data_t;

  // one enable per byte lane
  typedef logic [BE_W-1:0] obi_be_t;

  // where an accepted request went, held for its response cycle.
  // all flags low means no response is owed
  typedef struct packed {
    logic [1:0] bank;
    logic       bank_hit;
    logic       periph_hit;
    logic       none_hit;
  } tgt_sel_t;

endpackage

`default_nettype wire

/* common/obi_if.sv */
/*
 * OBI request/grant/response-valid link between the bus and one target.
 * Bus side uses master, target uses slave, response collector uses monitor.
 */
`timescale 1ns/1ns
`default_nettype none

interface obi_if;

  logic                    req;
  logic                    gnt;
  mini_mcu_pkg::obi_addr_t addr;
  logic                    we;
  mini_mcu_pkg::obi_be_t   be;
  mini_mcu_pkg::obi_data_t wdata;
  logic                    rvalid;
  mini_mcu_pkg::obi_data_t rdata;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

  // response side only
  modport monitor (
    input rvalid, rdata
  );

endinterface

`default_nettype wire

/* system_bus/system_bus_demux.sv */
/*
 * Request side of the system bus: decodes the master address to one RAM bank,
 * the control peripheral or nothing, and records the target for the response.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mini_mcu_params.svh"

module system_bus_demux (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  mini_mcu_pkg::obi_addr_t addr_i,
  input  mini_mcu_pkg::obi_be_t   be_i,
  input  mini_mcu_pkg::obi_data_t wdata_i,
  output logic                    gnt_o,
  output mini_mcu_pkg::tgt_sel_t  sel_o,
  obi_if.master                   bank_o [0:`MEM_BANKS-1],
  obi_if.master                   periph_o
);

  localparam int unsigned BANK_AW = $clog2(`BANK_WORDS);
  localparam int unsigned BANK_IW = $clog2(`MEM_BANKS);
  localparam mini_mcu_pkg::obi_addr_t MEM_SPAN = `MEM_BANKS * `BANK_WORDS * 4;

  mini_mcu_pkg::obi_addr_t mem_off;
  mini_mcu_pkg::obi_addr_t periph_off;
  logic                    mem_hit;
  logic                    periph_hit;
  logic [BANK_IW-1:0]      bank_idx;
  logic [`MEM_BANKS-1:0]   bank_gnt;
  mini_mcu_pkg::tgt_sel_t  sel_d;

  // offsets wrap below the base, so one compare per window is enough
  assign mem_off    = addr_i - `MEM_BASE;
  assign periph_off = addr_i - `PERIPH_BASE;
  assign mem_hit    = mem_off < MEM_SPAN;
  assign periph_hit = !mem_hit && (periph_off < `PERIPH_SIZE);
  assign bank_idx   = mem_off[BANK_AW+2 +: BANK_IW];

  for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
    assign bank_o[i].req   = req_i && mem_hit && (bank_idx == BANK_IW'(i));
    assign bank_o[i].addr  = mini_mcu_pkg::obi_addr_t'(mem_off[2 +: BANK_AW]);
    assign bank_o[i].we    = we_i;
    assign bank_o[i].be    = be_i;
    assign bank_o[i].wdata = wdata_i;
    assign bank_gnt[i]     = bank_o[i].gnt;
  end

  // peripheral sees its word index
  assign periph_o.req   = req_i && periph_hit;
  assign periph_o.addr  = mini_mcu_pkg::obi_addr_t'(periph_off[3:2]);
  assign periph_o.we    = we_i;
  assign periph_o.be    = be_i;
  assign periph_o.wdata = wdata_i;

  // targets are always ready; unmapped requests are granted here
  always_comb begin
    if (mem_hit) begin
      gnt_o = bank_gnt[bank_idx];
    end else if (periph_hit) begin
      gnt_o = periph_o.gnt;
    end else begin
      gnt_o = req_i;
    end
  end

  always_comb begin
    sel_d            = '0;
    sel_d.bank       = mem_hit ? bank_idx : '0;
    sel_d.bank_hit   = mem_hit;
    sel_d.periph_hit = periph_hit;
    sel_d.none_hit   = !mem_hit && !periph_hit;
  end

  // cleared in cycles without acceptance
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_o <= '0;
    end else if (req_i && gnt_o) begin
      sel_o <= sel_d;
    end else begin
      sel_o <= '0;
    end
  end

endmodule

`default_nettype wire

/* system_bus/system_bus_resp_mux.sv */
/*
 * Response side of the system bus: returns the response of the target picked
 * one cycle earlier by the demux, and answers unmapped requests itself.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mini_mcu_params.svh"

module system_bus_resp_mux (
  input  mini_mcu_pkg::tgt_sel_t  sel_i,
  obi_if.monitor                  bank_i [0:`MEM_BANKS-1],
  obi_if.monitor                  periph_i,
  output logic                    rvalid_o,
  output mini_mcu_pkg::obi_data_t rdata_o
);

  logic [`MEM_BANKS-1:0]   bank_rvalid;
  mini_mcu_pkg::obi_data_t bank_rdata [0:`MEM_BANKS-1];

  for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
    assign bank_rvalid[i] = bank_i[i].rvalid;
    assign bank_rdata[i]  = bank_i[i].rdata;
  end

  always_comb begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    if (sel_i.bank_hit) begin
      rvalid_o = bank_rvalid[sel_i.bank];
      rdata_o  = bank_rdata[sel_i.bank];
    end else if (sel_i.periph_hit) begin
      rvalid_o = periph_i.rvalid;
      rdata_o  = periph_i.rdata;
    end else if (sel_i.none_hit) begin
      // unmapped reads return zero
      rvalid_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/ram_bank.sv */
/*
 * Single-port word RAM on an OBI slave link, with byte-enable writes.
 * Always grants; the response follows acceptance by one cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module ram_bank #(
  parameter int unsigned DEPTH = 256
) (
  input  logic clk_i,
  input  logic reset_i,
  obi_if.slave bus
);

  localparam int unsigned AW = $clog2(DEPTH);

  mini_mcu_pkg::obi_data_t mem [DEPTH];
  mini_mcu_pkg::obi_data_t rdata_q;
  logic                    rvalid_q;
  logic                    accept;
  logic [AW-1:0]           word_addr;

  assign bus.gnt   = bus.req;
  assign accept    = bus.req && bus.gnt;
  assign word_addr = bus.addr[AW-1:0];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.be[b]) begin
            mem[word_addr][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_addr];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

/* rtl/soc_ctrl.sv */
/*
 * Control peripheral: program exit value with sticky valid, a scratch word
 * and a read-only ID, on an OBI slave link addressed by word index.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mini_mcu_params.svh"

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  obi_if.slave                    bus,
  output mini_mcu_pkg::obi_data_t exit_value_o,
  output logic                    exit_valid_o
);

  mini_mcu_pkg::obi_data_t exit_value_q;
  mini_mcu_pkg::obi_data_t scratch_q;
  mini_mcu_pkg::obi_data_t rdata_q;
  logic                    exit_valid_q;
  logic                    rvalid_q;
  logic                    accept;
  logic [1:0]              reg_idx;

  assign bus.gnt = bus.req;
  assign accept  = bus.req && bus.gnt;
  assign reg_idx = bus.addr[1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      scratch_q    <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= accept;
      if (accept && bus.we) begin
        case (reg_idx)
          2'd0: begin
            exit_value_q <= bus.wdata;
            exit_valid_q <= 1'b1;
          end
          2'd1: begin
            for (int b = 0; b < 4; b++) begin
              if (bus.be[b]) begin
                scratch_q[8*b +: 8] <= bus.wdata[8*b +: 8];
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  // read data sampled before this cycle's write lands
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else begin
        case (reg_idx)
          2'd0:    rdata_q <= exit_value_q;
          2'd1:    rdata_q <= scratch_q;
          2'd2:    rdata_q <= `SOC_ID;
          default: rdata_q <= '0;
        endcase
      end
    end
  end

  assign bus.rvalid   = rvalid_q;
  assign bus.rdata    = rdata_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

`default_nettype wire

/* rtl/mini_mcu.sv */
/*
 * Top level of the mini MCU bus-and-memory slice. An external OBI master
 * drives the plain bus ports; the exit value comes out of the control block.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mini_mcu_params.svh"

module mini_mcu (
  input  logic                    clk_i,
  input  logic                    reset_i,

  // external bus master
  input  logic                    bus_req_i,
  input  logic                    bus_we_i,
  input  mini_mcu_pkg::obi_addr_t bus_addr_i,
  input  mini_mcu_pkg::obi_be_t   bus_be_i,
  input  mini_mcu_pkg::obi_data_t bus_wdata_i,
  output logic                    bus_gnt_o,
  output logic                    bus_rvalid_o,
  output mini_mcu_pkg::obi_data_t bus_rdata_o,

  output mini_mcu_pkg::obi_data_t exit_value_o,
  output logic                    exit_valid_o
);

  // target of the request accepted last cycle
  mini_mcu_pkg::tgt_sel_t tgt_sel;

  obi_if bank_bus [0:`MEM_BANKS-1] ();
  obi_if periph_bus ();

  system_bus_demux system_bus_demux_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (bus_req_i),
    .we_i    (bus_we_i),
    .addr_i  (bus_addr_i),
    .be_i    (bus_be_i),
    .wdata_i (bus_wdata_i),
    .gnt_o   (bus_gnt_o),
    .sel_o   (tgt_sel),
    .bank_o  (bank_bus),
    .periph_o(periph_bus)
  );

  system_bus_resp_mux system_bus_resp_mux_i (
    .sel_i   (tgt_sel),
    .bank_i  (bank_bus),
    .periph_i(periph_bus),
    .rvalid_o(bus_rvalid_o),
    .rdata_o (bus_rdata_o)
  );

  for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_ram
    ram_bank #(
      .DEPTH(`BANK_WORDS)
    ) ram_bank_i (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .bus    (bank_bus[i])
    );
  end

  soc_ctrl soc_ctrl_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus         (periph_bus),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

`default_nettype wire

/* dv/mini_mcu_checker.sv */
/*
 * Protocol assertions on the external bus port of the mini MCU.
 * Bound into every mini_mcu instance by the bind statement below.
 */
`timescale 1ns/1ns
`default_nettype none

module mini_mcu_checker (
  input logic clk_i,
  input logic reset_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic exit_valid_i
);

  // one response in the cycle after each accepted request, none otherwise
  resp_timing: assert property (
    @(posedge clk_i) disable iff (reset_i)
      rvalid_i == $past(req_i && gnt_i)
  ) else $error("bus response not exactly one cycle after acceptance");

  gnt_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
      gnt_i |-> req_i
  ) else $error("grant without request");

  // exit valid is sticky until reset
  exit_valid_sticky: assert property (
    @(posedge clk_i) disable iff (reset_i)
      !$fell(exit_valid_i)
  ) else $error("exit valid dropped outside reset");

endmodule

bind mini_mcu mini_mcu_checker mini_mcu_checker_i (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .req_i       (bus_req_i),
  .gnt_i       (bus_gnt_o),
  .rvalid_i    (bus_rvalid_o),
  .exit_valid_i(exit_valid_o)
);

`default_nettype wire

/* dv/tb_mini_mcu.sv */
/*
 * Testbench for the mini MCU slice. Drives the external OBI master port,
 * predicts every response with a reference model and checks them in order.
 */
`timescale 1ns/1ns
`default_nettype none

`include "mini_mcu_params.svh"

module tb_mini_mcu;

  localparam int MEM_WORDS  = `MEM_BANKS * `BANK_WORDS;
  localparam int MEM_AW     = $clog2(MEM_WORDS);
  localparam int BANK_AW    = $clog2(`BANK_WORDS);
  localparam int BANK_BYTES = `BANK_WORDS * 4;
  localparam mini_mcu_pkg::obi_addr_t MEM_SPAN = MEM_WORDS * 4;
  localparam int N_EDGE = 2 * `MEM_BANKS;
  localparam int N_RAND = 32;
  localparam int N_PART = 16;
  localparam int N_MIX  = 48;
  localparam int N_UNMAPPED = 4;
  localparam mini_mcu_pkg::obi_addr_t UNMAPPED [N_UNMAPPED] = '{
    `PERIPH_BASE + `PERIPH_SIZE, `MEM_BASE + MEM_SPAN, 32'h0001_0000, 32'hffff_fffc
  };
  // bus operations over all phases with the id and exit phases last
  localparam int N_OPS = 2 * (N_EDGE + N_RAND) + 2 * N_PART + N_MIX
                       + 2 * N_UNMAPPED + 3 + 4;
  localparam int WATCHDOG_CYCLES = N_OPS * 4 + 100;
  localparam int GNT_LIMIT   = 16;
  localparam int DRAIN_LIMIT = 16;

  logic                    clk_i;
  logic                    reset_i;
  logic                    bus_req_i;
  logic                    bus_we_i;
  mini_mcu_pkg::obi_addr_t bus_addr_i;
  mini_mcu_pkg::obi_be_t   bus_be_i;
  mini_mcu_pkg::obi_data_t bus_wdata_i;
  logic                    bus_gnt_o;
  logic                    bus_rvalid_o;
  mini_mcu_pkg::obi_data_t bus_rdata_o;
  mini_mcu_pkg::obi_data_t exit_value_o;
  logic                    exit_valid_o;

  // reference state and expected responses
  mini_mcu_pkg::obi_data_t model_mem [MEM_WORDS];
  mini_mcu_pkg::obi_data_t model_scratch;
  mini_mcu_pkg::obi_data_t model_exit;
  mini_mcu_pkg::obi_data_t exp_q [$];
  mini_mcu_pkg::obi_addr_t written_q [$];
  logic [31:0]             lfsr_q;
  int                      n_checks;

  mini_mcu mini_mcu_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_be_i    (bus_be_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_gnt_o   (bus_gnt_o),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o (bus_rdata_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic mini_mcu_pkg::obi_data_t merge_bytes(
    input mini_mcu_pkg::obi_data_t old_word,
    input mini_mcu_pkg::obi_data_t new_word,
    input mini_mcu_pkg::obi_be_t   be
  );
    mini_mcu_pkg::obi_data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic mini_mcu_pkg::obi_data_t ref_read(input mini_mcu_pkg::obi_addr_t addr);
    mini_mcu_pkg::obi_addr_t mem_off;
    mini_mcu_pkg::obi_addr_t per_off;
    mem_off = addr - `MEM_BASE;
    per_off = addr - `PERIPH_BASE;
    if (mem_off < MEM_SPAN) begin
      return model_mem[mem_off[MEM_AW+1:2]];
    end
    if (per_off < `PERIPH_SIZE) begin
      case (per_off[3:2])
        2'd0:    return model_exit;
        2'd1:    return model_scratch;
        2'd2:    return `SOC_ID;
        default: return '0;
      endcase
    end
    return '0;
  endfunction

  task automatic model_write(
    input mini_mcu_pkg::obi_addr_t addr,
    input mini_mcu_pkg::obi_be_t   be,
    input mini_mcu_pkg::obi_data_t wdata
  );
    mini_mcu_pkg::obi_addr_t mem_off;
    mini_mcu_pkg::obi_addr_t per_off;
    mem_off = addr - `MEM_BASE;
    per_off = addr - `PERIPH_BASE;
    if (mem_off < MEM_SPAN) begin
      model_mem[mem_off[MEM_AW+1:2]] = merge_bytes(model_mem[mem_off[MEM_AW+1:2]], wdata, be);
    end else if (per_off < `PERIPH_SIZE && per_off[3:2] == 2'd0) begin
      model_exit = wdata;
    end else if (per_off < `PERIPH_SIZE && per_off[3:2] == 2'd1) begin
      model_scratch = merge_bytes(model_scratch, wdata, be);
    end
  endtask

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(
    input mini_mcu_pkg::obi_data_t got,
    input mini_mcu_pkg::obi_data_t expected,
    input string                   what
  );
    n_checks++;
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  // samples on the falling edge, where the outputs are settled
  task automatic check_exit(
    input mini_mcu_pkg::obi_data_t exp_value,
    input logic                    exp_valid,
    input string                   what
  );
    @(negedge clk_i);
    n_checks++;
    if (exit_value_o !== exp_value || exit_valid_o !== exp_valid) begin
      $display("FAILED at %0t ns: %s is %h/%b, expected %h/%b", $time, what,
               exit_value_o, exit_valid_o, exp_value, exp_valid);
      abort_run();
    end
  endtask

  // holds the request until granted, then predicts its response
  task automatic bus_op(
    input logic                    we,
    input mini_mcu_pkg::obi_addr_t addr,
    input mini_mcu_pkg::obi_be_t   be,
    input mini_mcu_pkg::obi_data_t wdata
  );
    int wait_cycles;
    wait_cycles = 0;
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    @(posedge clk_i);
    while (!bus_gnt_o) begin
      wait_cycles++;
      if (wait_cycles > GNT_LIMIT) begin
        $display("request to %h was never granted", addr);
        abort_run();
      end
      @(posedge clk_i);
    end
    if (we) begin
      exp_q.push_back('0);
      model_write(addr, be, wdata);
    end else begin
      exp_q.push_back(ref_read(addr));
    end
  endtask

  task automatic drain_responses();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    bus_req_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("%0d responses still missing after the bus went idle", exp_q.size());
        abort_run();
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i && bus_rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t ns with no request outstanding", $time);
        abort_run();
      end else begin
        check_data(bus_rdata_o, exp_q.pop_front(), "bus_rdata_o");
      end
    end
  end

  initial begin
    mini_mcu_pkg::obi_addr_t addr;
    mini_mcu_pkg::obi_data_t data;
    mini_mcu_pkg::obi_addr_t last_wr [`MEM_BANKS];
    logic [31:0]             bits;
    logic                    we;
    int                      pick;

    reset_i       = 1'b1;
    bus_req_i     = 1'b0;
    bus_we_i      = 1'b0;
    bus_addr_i    = '0;
    bus_be_i      = '0;
    bus_wdata_i   = '0;
    lfsr_q        = 32'hd29e_f7db;
    n_checks      = 0;
    model_scratch = '0;
    model_exit    = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    @(negedge clk_i);
    n_checks++;
    if (bus_rvalid_o !== 1'b0) begin
      $display("FAILED at %0t ns: bus_rvalid_o is %b after reset, expected 0",
               $time, bus_rvalid_o);
      abort_run();
    end
    check_exit('0, 1'b0, "exit after reset");

    // full words at the first and last word of each bank, then random words
    for (int b = 0; b < `MEM_BANKS; b++) begin
      written_q.push_back(`MEM_BASE + b * BANK_BYTES);
      written_q.push_back(`MEM_BASE + (b + 1) * BANK_BYTES - 4);
    end
    for (int k = 0; k < N_RAND; k++) begin
      take_bits(MEM_AW, bits);
      written_q.push_back(`MEM_BASE + (bits << 2));
    end
    foreach (written_q[k]) begin
      take_bits(32, data);
      bus_op(1'b1, written_q[k], 4'hf, data);
    end
    foreach (written_q[k]) begin
      bus_op(1'b0, written_q[k], 4'h0, '0);
    end
    drain_responses();

    // partial writes on defined words with every fourth one to scratch
    for (int k = 0; k < N_PART; k++) begin
      take_bits(16, bits);
      pick = int'(bits) % written_q.size();
      addr = (k % 4 == 3) ? `PERIPH_BASE + 32'd4 : written_q[pick];
      take_bits(4, bits);
      take_bits(32, data);
      bus_op(1'b1, addr, bits[3:0], data);
      bus_op(1'b0, addr, 4'h0, '0);
    end
    drain_responses();

    // one request per cycle to the banks in turn and the peripheral
    // reads fetch the last word written to their bank
    for (int b = 0; b < `MEM_BANKS; b++) begin
      last_wr[b] = `MEM_BASE + b * BANK_BYTES;
    end
    for (int k = 0; k < N_MIX; k++) begin
      take_bits(1, bits);
      we = bits[0];
      if (k % 3 == 2) begin
        take_bits(2, bits);
        addr = `PERIPH_BASE + 32'd4 * (32'd1 + bits % 32'd3);
      end else if (we) begin
        take_bits(BANK_AW, bits);
        addr = `MEM_BASE + (k % `MEM_BANKS) * BANK_BYTES + (bits << 2);
        last_wr[k % `MEM_BANKS] = addr;
      end else begin
        addr = last_wr[k % `MEM_BANKS];
      end
      take_bits(32, data);
      bus_op(we, addr, 4'hf, data);
    end
    drain_responses();

    foreach (UNMAPPED[k]) begin
      take_bits(32, data);
      bus_op(1'b1, UNMAPPED[k], 4'hf, data);
      bus_op(1'b0, UNMAPPED[k], 4'h0, '0);
    end
    bus_op(1'b0, `MEM_BASE, 4'h0, '0);
    bus_op(1'b0, `PERIPH_BASE + 32'd8, 4'h0, '0);
    bus_op(1'b0, `PERIPH_BASE + 32'd12, 4'h0, '0);
    drain_responses();
    check_exit('0, 1'b0, "exit before any exit write");

    take_bits(32, data);
    bus_op(1'b1, `PERIPH_BASE, 4'hf, data);
    bus_op(1'b0, `PERIPH_BASE, 4'h0, '0);
    drain_responses();
    check_exit(data, 1'b1, "exit after first write");
    take_bits(32, data);
    bus_op(1'b1, `PERIPH_BASE, 4'hf, data);
    bus_op(1'b0, `PERIPH_BASE, 4'h0, '0);
    drain_responses();
    check_exit(data, 1'b1, "exit after second write");

    @(negedge clk_i);
    if (n_checks > 0 && exp_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("run ended with %0d checks and %0d responses outstanding",
               n_checks, exp_q.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/mini_mcu_pkg.sv
common/obi_if.sv
system_bus/system_bus_demux.sv
system_bus/system_bus_resp_mux.sv
rtl/ram_bank.sv
rtl/soc_ctrl.sv
rtl/mini_mcu.sv
dv/mini_mcu_checker.sv
dv/tb_mini_mcu.sv

/* Makefile */
# Verilator build and run of the mini MCU testbench.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mini_mcu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := *** TEST FAILED ***
PASS_MSG := *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "no pass result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
